// File: design/audioTxPkg.sv
/* Audio TX shared definitions */
package audioTxPkg;

	//----------------------------------------------------------------------
	// Widths
	//----------------------------------------------------------------------
	localparam int memAdrsWidth = 19;	// One memory word per address
	localparam int dataWidth    = 32;	// Bus word and sample width
	localparam int csrAdrsWidth = 8;	// Offset field of AWADDR / ARADDR

	//----------------------------------------------------------------------
	// Register map
	//----------------------------------------------------------------------
	localparam logic [csrAdrsWidth-1:0] regDmaAdrs = 8'h10;	// Start word address
	localparam logic [csrAdrsWidth-1:0] regDmaLen  = 8'h14;	// Length in words
	localparam logic [csrAdrsWidth-1:0] regDmaEn   = 8'h18;	// Enable, bit 0
	localparam logic [csrAdrsWidth-1:0] regStatus  = 8'h1C;	// Busy, done, underflow

	localparam logic [memAdrsWidth-1:0] dmaAdrsReset = 19'h40000;
	localparam logic [memAdrsWidth-1:0] dmaLenReset  = 19'h30000;

	// AXI response codes
	localparam logic [1:0] respOkay   = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	//----------------------------------------------------------------------
	// Playback timing and buffering
	//----------------------------------------------------------------------
	localparam int samplePeriod   = 16;	// Clocks per output sample
	localparam int sampleCntWidth = $clog2(samplePeriod);
	localparam logic [sampleCntWidth-1:0] sampleReload = sampleCntWidth'(samplePeriod - 1);

	localparam int fifoDepth    = 4;	// Power of two so pointers wrap
	localparam int fifoPtrWidth = $clog2(fifoDepth);
	localparam logic [fifoPtrWidth:0] fifoFullCnt = (fifoPtrWidth + 1)'(fifoDepth);

	//----------------------------------------------------------------------
	// Bundles
	//----------------------------------------------------------------------
	typedef struct packed {
		logic [memAdrsWidth-1:0] adrs;
		logic [memAdrsWidth-1:0] len;
		logic                    en;
	} dmaCfg;

	typedef struct packed {
		logic busy;
		logic done;
	} dmaStat;

	typedef struct packed {
		logic                    valid;
		logic [memAdrsWidth-1:0] adrs;
	} memReq;

	typedef struct packed {
		logic                 valid;
		logic [dataWidth-1:0] data;
	} memRsp;

	typedef struct packed {
		logic                 valid;
		logic [dataWidth-1:0] data;
	} audioSample;

	typedef enum logic [1:0] {
		stIdle,
		stRequest,
		stWait,
		stDone
	} dmaState;

endpackage

// File: design/audioTxCsr.sv
/* AXI4-Lite control and status registers */
module audioTxCsr (
	input  logic                                  iSysClk,
	input  logic                                  rst,
	// Write channels
	input  logic                                  awvalid,
	output logic                                  awready,
	input  logic [audioTxPkg::csrAdrsWidth-1:0]   awaddr,
	input  logic                                  wvalid,
	output logic                                  wready,
	input  logic [audioTxPkg::dataWidth-1:0]      wdata,
	output logic                                  bvalid,
	input  logic                                  bready,
	output logic [1:0]                            bresp,
	// Read channels
	input  logic                                  arvalid,
	output logic                                  arready,
	input  logic [audioTxPkg::csrAdrsWidth-1:0]   araddr,
	output logic                                  rvalid,
	input  logic                                  rready,
	output logic [audioTxPkg::dataWidth-1:0]      rdata,
	output logic [1:0]                            rresp,
	// DMA side
	output audioTxPkg::dmaCfg                     cfg,
	input  audioTxPkg::dmaStat                    stat,
	input  logic                                  underflow
);
	logic wrEn;				// Write accepted this cycle
	logic rdEn;				// Read accepted this cycle
	logic underflowSticky;

	// Offset hits one of the four registers
	function automatic logic isReg(input logic [audioTxPkg::csrAdrsWidth-1:0] ofs);
		isReg = (ofs == audioTxPkg::regDmaAdrs) || (ofs == audioTxPkg::regDmaLen) ||
			(ofs == audioTxPkg::regDmaEn) || (ofs == audioTxPkg::regStatus);
	endfunction

	assign wrEn = awvalid & awready & wvalid & wready;
	assign rdEn = arvalid & arready;

	//----------------------------------------------------------------------
	// Handshake
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end
		else
		begin
			// Ready for one cycle once both halves present and none pending
			awready <= ~awready & awvalid & wvalid & ~bvalid;
			wready  <= ~awready & awvalid & wvalid & ~bvalid;
			if (wrEn)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;	// Held until taken
			arready <= ~arready & arvalid & ~rvalid;
			if (rdEn)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	//----------------------------------------------------------------------
	// Config registers and sticky underflow
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			cfg <= '{adrs: audioTxPkg::dmaAdrsReset, len: audioTxPkg::dmaLenReset,
				en: 1'b0};
			underflowSticky <= 1'b0;
		end
		else
		begin
			if (wrEn)
			begin
				case (awaddr)
					audioTxPkg::regDmaAdrs: cfg.adrs <= wdata[audioTxPkg::memAdrsWidth-1:0];
					audioTxPkg::regDmaLen:  cfg.len  <= wdata[audioTxPkg::memAdrsWidth-1:0];
					audioTxPkg::regDmaEn:   cfg.en   <= wdata[0];
					default: ;			// Status clear handled below
				endcase
			end
			if (underflow)
				underflowSticky <= 1'b1;	// New event beats a clear
			else if (wrEn && (awaddr == audioTxPkg::regStatus))
				underflowSticky <= 1'b0;
		end
	end

	// Response codes and read data
	always_ff @(posedge iSysClk)
	begin
		if (wrEn)
			bresp <= isReg(awaddr) ? audioTxPkg::respOkay : audioTxPkg::respSlvErr;
		if (rdEn)
		begin
			rresp <= isReg(araddr) ? audioTxPkg::respOkay : audioTxPkg::respSlvErr;
			case (araddr)
				audioTxPkg::regDmaAdrs:
					rdata <= {{(audioTxPkg::dataWidth - audioTxPkg::memAdrsWidth){1'b0}}, cfg.adrs};
				audioTxPkg::regDmaLen:
					rdata <= {{(audioTxPkg::dataWidth - audioTxPkg::memAdrsWidth){1'b0}}, cfg.len};
				audioTxPkg::regDmaEn:
					rdata <= {{(audioTxPkg::dataWidth - 1){1'b0}}, cfg.en};
				audioTxPkg::regStatus:	// Bit 0 busy, 1 done, 2 underflow
					rdata <= {{(audioTxPkg::dataWidth - 3){1'b0}},
						underflowSticky, stat.done, stat.busy};
				default:
					rdata <= '0;
			endcase
		end
	end

endmodule

// File: design/audioDmaCtrl.sv
/* Audio DMA read sequencer */
module audioDmaCtrl (
	input  logic                   iSysClk,
	input  logic                   rst,
	input  audioTxPkg::dmaCfg      cfg,
	output audioTxPkg::dmaStat     stat,
	input  logic                   fifoRoom,	// Space for one more word
	input  logic                   fifoEmpty,
	input  audioTxPkg::memRsp      rsp,
	output audioTxPkg::memReq      req,
	output logic                   run			// Timer enable
);
	audioTxPkg::dmaState                 state;
	logic [audioTxPkg::memAdrsWidth-1:0] adrsCnt;	// Next word address
	logic [audioTxPkg::memAdrsWidth-1:0] remCnt;	// Words still to fetch
	logic                                lastWord;

	assign lastWord = (remCnt == {{(audioTxPkg::memAdrsWidth - 1){1'b0}}, 1'b1});

	//----------------------------------------------------------------------
	// State machine
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			state <= audioTxPkg::stIdle;
			run   <= 1'b0;
		end
		else
		begin
			case (state)
				audioTxPkg::stIdle:
				begin
					run <= cfg.en;	// Playback starts with the fetch
					if (cfg.en)
						state <= (cfg.len == '0) ? audioTxPkg::stDone : audioTxPkg::stRequest;
				end
				audioTxPkg::stRequest:
					if (fifoRoom)
						state <= audioTxPkg::stWait;	// Request goes out this cycle
				audioTxPkg::stWait:
					if (rsp.valid)
						state <= lastWord ? audioTxPkg::stDone : audioTxPkg::stRequest;
				audioTxPkg::stDone:
				begin
					if (fifoEmpty)
						run <= 1'b0;	// Drained
					if (!cfg.en)
						state <= audioTxPkg::stIdle;
				end
				default:
					state <= audioTxPkg::stIdle;
			endcase
		end
	end

	// Address and word counters loaded while idle
	always_ff @(posedge iSysClk)
	begin
		if (state == audioTxPkg::stIdle)
		begin
			adrsCnt <= cfg.adrs;
			remCnt  <= cfg.len;
		end
		else if ((state == audioTxPkg::stWait) && rsp.valid)
		begin
			adrsCnt <= adrsCnt + 1'b1;	// Ascending order
			remCnt  <= remCnt - 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// Outputs
	//----------------------------------------------------------------------
	// Single cycle request since stRequest always moves on when it fires
	assign req = '{valid: (state == audioTxPkg::stRequest) && fifoRoom, adrs: adrsCnt};

	assign stat = '{
		busy: (state == audioTxPkg::stRequest) || (state == audioTxPkg::stWait),
		done: (state == audioTxPkg::stDone)
	};

endmodule

// File: design/sampleRateTimer.sv
/* Sample period timer */
module sampleRateTimer (
	input  logic iSysClk,
	input  logic rst,
	input  logic run,
	output logic tick	// One cycle per sample period
);
	logic [audioTxPkg::sampleCntWidth-1:0] cnt;

	always_ff @(posedge iSysClk)
	begin
		if (rst || !run)
		begin
			cnt  <= audioTxPkg::sampleReload;	// Full period after run rises
			tick <= 1'b0;
		end
		else
		begin
			tick <= (cnt == '0);	// Registered so it lands samplePeriod after start
			if (cnt == '0)
				cnt <= audioTxPkg::sampleReload;
			else
				cnt <= cnt - 1'b1;
		end
	end

endmodule

// File: design/audioSampleFifo.sv
/* Sample FIFO with underflow detect */
module audioSampleFifo (
	input  logic                    iSysClk,
	input  logic                    rst,
	input  audioTxPkg::memRsp       wr,			// Memory response pushed as is
	input  logic                    tick,
	input  logic                    pending,	// Request issued this cycle
	output logic                    room,
	output logic                    empty,
	output audioTxPkg::audioSample  sample,
	output logic                    underflow
);
	logic [audioTxPkg::dataWidth-1:0]  mem [audioTxPkg::fifoDepth];
	logic [audioTxPkg::fifoPtrWidth-1:0] wrPtr;
	logic [audioTxPkg::fifoPtrWidth-1:0] rdPtr;
	logic [audioTxPkg::fifoPtrWidth:0]   count;
	logic [audioTxPkg::fifoPtrWidth:0]   used;	// Stored plus in flight
	logic                              outstanding;
	logic                              pop;
	logic                              sampleValid;
	logic [audioTxPkg::dataWidth-1:0]  sampleData;

	assign empty = (count == '0);
	assign pop   = tick & ~empty;
	assign used  = count + {{audioTxPkg::fifoPtrWidth{1'b0}}, outstanding};
	assign room  = (used < audioTxPkg::fifoFullCnt);

	//----------------------------------------------------------------------
	// Pointers, count, flags
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			wrPtr       <= '0;
			rdPtr       <= '0;
			count       <= '0;
			outstanding <= 1'b0;
			sampleValid <= 1'b0;
			underflow   <= 1'b0;
		end
		else
		begin
			if (wr.valid)
				wrPtr <= wrPtr + 1'b1;	// Wraps at fifoDepth
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({wr.valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;				// Both or neither
			endcase
			if (pending)
				outstanding <= 1'b1;	// Reserve a slot for the reply
			else if (wr.valid)
				outstanding <= 1'b0;
			sampleValid <= pop;
			underflow   <= tick & empty;	// Tick with nothing to play
		end
	end

	// Storage and output word
	always_ff @(posedge iSysClk)
	begin
		if (wr.valid)
			mem[wrPtr] <= wr.data;
		if (pop)
			sampleData <= mem[rdPtr];
	end

	assign sample = '{valid: sampleValid, data: sampleData};

endmodule

// File: design/audioTxTop.sv
/* Audio playback subsystem */
module audioTxTop (
	input  logic                                iSysClk,
	input  logic                                rst,
	// AXI4-Lite slave
	input  logic                                awvalid,
	output logic                                awready,
	input  logic [audioTxPkg::csrAdrsWidth-1:0] awaddr,
	input  logic                                wvalid,
	output logic                                wready,
	input  logic [audioTxPkg::dataWidth-1:0]    wdata,
	output logic                                bvalid,
	input  logic                                bready,
	output logic [1:0]                          bresp,
	input  logic                                arvalid,
	output logic                                arready,
	input  logic [audioTxPkg::csrAdrsWidth-1:0] araddr,
	output logic                                rvalid,
	input  logic                                rready,
	output logic [audioTxPkg::dataWidth-1:0]    rdata,
	output logic [1:0]                          rresp,
	// Memory and audio
	output audioTxPkg::memReq                   memReqOut,
	input  audioTxPkg::memRsp                   memRspIn,
	output audioTxPkg::audioSample              audioOut
);
	audioTxPkg::dmaCfg  dmaCfgBus;
	audioTxPkg::dmaStat dmaStatBus;
	logic underflow;	// One cycle pulse from FIFO to CSR
	logic fifoRoom;
	logic fifoEmpty;
	logic run;
	logic tick;

	//----------------------------------------------------------------------
	// Register block
	//----------------------------------------------------------------------
	audioTxCsr csr (
		.iSysClk(iSysClk), .rst(rst),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.cfg(dmaCfgBus), .stat(dmaStatBus), .underflow(underflow)
	);

	//----------------------------------------------------------------------
	// Fetch, pacing, buffering
	//----------------------------------------------------------------------
	audioDmaCtrl dmaCtrl (
		.iSysClk(iSysClk), .rst(rst),
		.cfg(dmaCfgBus), .stat(dmaStatBus),
		.fifoRoom(fifoRoom), .fifoEmpty(fifoEmpty),
		.rsp(memRspIn), .req(memReqOut), .run(run)
	);

	sampleRateTimer timer (
		.iSysClk(iSysClk), .rst(rst), .run(run), .tick(tick)
	);

	// Issued request marks the slot as in flight
	audioSampleFifo fifo (
		.iSysClk(iSysClk), .rst(rst),
		.wr(memRspIn), .tick(tick), .pending(memReqOut.valid),
		.room(fifoRoom), .empty(fifoEmpty),
		.sample(audioOut), .underflow(underflow)
	);

endmodule

// File: bench/audioTxTop_properties.sv
/* Audio TX protocol checks */
module audioTxTop_properties (
	input  logic                   iSysClk,
	input  logic                   rst,
	input  logic                   awready,
	input  logic                   wready,
	input  logic                   bvalid,
	input  logic                   bready,
	input  logic                   arready,
	input  logic                   rvalid,
	input  logic                   rready,
	input  audioTxPkg::memReq      memReqOut,
	input  audioTxPkg::memRsp      memRspIn,
	input  audioTxPkg::audioSample audioOut,
	input  logic                   fifoEmpty,
	input  logic                   run
);
	logic       reqOpen;		// Request issued and reply not back yet
	logic [7:0] sinceSample;	// Saturating cycles since last sample
	logic       sampleSeen;

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			reqOpen     <= 1'b0;
			sinceSample <= 8'd0;
			sampleSeen  <= 1'b0;
		end
		else
		begin
			if (memReqOut.valid)
				reqOpen <= 1'b1;
			else if (memRspIn.valid)
				reqOpen <= 1'b0;
			if (audioOut.valid)
			begin
				sinceSample <= 8'd1;
				sampleSeen  <= 1'b1;
			end
			else if (sinceSample != 8'hFF)
				sinceSample <= sinceSample + 8'd1;
		end
	end

	//----------------------------------------------------------------------
	// AXI4-Lite responses
	//----------------------------------------------------------------------
	bvalidHold: assert property (@(posedge iSysClk) disable iff (rst)
		bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
	rvalidHold: assert property (@(posedge iSysClk) disable iff (rst)
		rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

	//----------------------------------------------------------------------
	// Memory port and sample pacing
	//----------------------------------------------------------------------
	reqSingle: assert property (@(posedge iSysClk) disable iff (rst)
		memReqOut.valid |-> !reqOpen)
		else $error("second memory request while one is open");
	sampleGap: assert property (@(posedge iSysClk) disable iff (rst)
		audioOut.valid && sampleSeen |-> sinceSample >= 8'(audioTxPkg::samplePeriod))
		else $error("audio samples closer than one sample period");
	// Next pop is due one cycle before the period ends
	sampleOnTime: assert property (@(posedge iSysClk) disable iff (rst)
		sampleSeen && run && !fifoEmpty && (sinceSample == 8'(audioTxPkg::samplePeriod - 1))
		|=> audioOut.valid) else $error("audio sample missing with data buffered");

	resetQuiet: assert property (@(posedge iSysClk) $fell(rst) |->
		!(awready || wready || bvalid || arready || rvalid || memReqOut.valid || audioOut.valid))
		else $error("control output active right after reset");

endmodule

// File: bench/audioTxTb.sv
/* Audio TX testbench */
module audioTxTb;

	localparam int clkPeriod     = 40;
	localparam int driveDelay    = 5;	// Input skew after rising edge
	localparam int timeoutCycles = 40 * audioTxPkg::samplePeriod + 2000;
	localparam logic [31:0] dataMask  = 32'h5A5A0000;	// Memory model pattern
	localparam logic [31:0] adrsMask  = (32'd1 << audioTxPkg::memAdrsWidth) - 32'd1;
	localparam logic [31:0] statDone  = 32'h2;
	localparam logic [31:0] statUnder = 32'h4;

	logic        iSysClk;
	logic        rst;
	logic        awvalid;
	logic        awready;
	logic [7:0]  awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	logic [7:0]  araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	audioTxPkg::memReq      memReqOut;
	audioTxPkg::memRsp      memRspIn;
	audioTxPkg::audioSample audioOut;

	string       testName;
	logic [31:0] expSamples [$];	// Every expected sample in play order
	int          samplesSeen = 0;
	int          forcedLatency;		// Zero means random latency
	int          cycleCnt = 0;
	logic [15:0] lfsr;

	audioTxTop i_dut (.*);

	bind audioTxTop audioTxTop_properties props (
		.iSysClk(iSysClk), .rst(rst), .awready(awready), .wready(wready),
		.bvalid(bvalid), .bready(bready), .arready(arready), .rvalid(rvalid),
		.rready(rready), .memReqOut(memReqOut), .memRspIn(memRspIn),
		.audioOut(audioOut), .fifoEmpty(fifoEmpty), .run(run)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #(clkPeriod / 2) iSysClk = ~iSysClk;
	end

	//----------------------------------------------------------------------
	// Failure and value checks
	//----------------------------------------------------------------------
	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual);
		assert (actual == expected)
		else abortRun($sformatf("mismatch %s expected 0x%08h actual 0x%08h",
			testName, expected, actual));
	endtask

	// Galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		lfsrNext = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic takeBits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			value = (value << 1) | int'(lfsr[0]);	// One step per bit
			lfsr = lfsrNext(lfsr);
		end
	endtask

	//----------------------------------------------------------------------
	// AXI4-Lite master
	//----------------------------------------------------------------------
	task automatic axiWrite(input logic [7:0] ofs, input logic [31:0] data,
		input logic [1:0] expResp);
		@(posedge iSysClk);
		#driveDelay;
		awvalid = 1'b1;
		awaddr  = ofs;
		wvalid  = 1'b1;
		wdata   = data;
		do @(negedge iSysClk); while (!(awready && wready));
		@(posedge iSysClk);
		#driveDelay;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		do @(negedge iSysClk); while (!bvalid);
		checkValue(32'(expResp), 32'(bresp));
		@(posedge iSysClk);
		#driveDelay bready = 1'b1;	// Late accept so bvalid must hold
		@(posedge iSysClk);
		#driveDelay bready = 1'b0;
	endtask

	task automatic axiRead(input logic [7:0] ofs, input logic [31:0] expData,
		input logic [1:0] expResp);
		@(posedge iSysClk);
		#driveDelay;
		arvalid = 1'b1;
		araddr  = ofs;
		do @(negedge iSysClk); while (!arready);
		@(posedge iSysClk);
		#driveDelay arvalid = 1'b0;
		do @(negedge iSysClk); while (!rvalid);
		checkValue(32'(expResp), 32'(rresp));
		checkValue(expData, rdata);
		@(posedge iSysClk);
		#driveDelay rready = 1'b1;
		@(posedge iSysClk);
		#driveDelay rready = 1'b0;
	endtask

	// Program a run and wait until all its samples have played
	task automatic playback(input logic [18:0] base, input int words);
		for (int i = 0; i < words; i++)
			expSamples.push_back(32'(base + 19'(i)) ^ dataMask);
		axiWrite(audioTxPkg::regDmaAdrs, 32'(base), audioTxPkg::respOkay);
		axiWrite(audioTxPkg::regDmaLen, 32'(words), audioTxPkg::respOkay);
		axiWrite(audioTxPkg::regDmaEn, 32'd1, audioTxPkg::respOkay);
		while (samplesSeen < expSamples.size())
			@(posedge iSysClk);
	endtask

	//----------------------------------------------------------------------
	// Memory model, sample checker, timeout
	//----------------------------------------------------------------------
	initial
	begin
		int lat;
		logic [audioTxPkg::memAdrsWidth-1:0] reqAdrs;
		memRspIn = '0;
		lfsr     = 16'd22213;
		forever
		begin
			@(negedge iSysClk);
			if (memReqOut.valid)
			begin
				reqAdrs = memReqOut.adrs;
				if (forcedLatency > 0)
					lat = forcedLatency;
				else
				begin
					takeBits(2, lat);
					lat = lat + 1;	// 1 to 4 cycles
				end
				repeat (lat) @(posedge iSysClk);
				#driveDelay;
				memRspIn = '{valid: 1'b1, data: 32'(reqAdrs) ^ dataMask};
				@(posedge iSysClk);
				#driveDelay memRspIn.valid = 1'b0;
			end
		end
	end

	always @(negedge iSysClk)
		if (audioOut.valid)
		begin
			if (samplesSeen >= expSamples.size())
				abortRun($sformatf("unexpected audio sample 0x%08h in %s",
					audioOut.data, testName));
			else
			begin
				checkValue(expSamples[samplesSeen], audioOut.data);
				samplesSeen = samplesSeen + 1;
			end
		end

	always @(posedge iSysClk)
	begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt >= timeoutCycles)
			abortRun($sformatf("timeout after %0d cycles in %s, run did not finish",
				cycleCnt, testName));
	end

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial
	begin
		rst           = 1'b1;
		awvalid       = 1'b0;
		awaddr        = '0;
		wvalid        = 1'b0;
		wdata         = '0;
		bready        = 1'b0;
		arvalid       = 1'b0;
		araddr        = '0;
		rready        = 1'b0;
		forcedLatency = 0;
		testName      = "reset";
		repeat (5) @(posedge iSysClk);
		#driveDelay rst = 1'b0;

		testName = "resetValues";
		axiRead(audioTxPkg::regDmaAdrs, 32'h40000, audioTxPkg::respOkay);
		axiRead(audioTxPkg::regDmaLen, 32'h30000, audioTxPkg::respOkay);
		axiRead(audioTxPkg::regDmaEn, 32'h0, audioTxPkg::respOkay);
		testName = "badOffset";
		axiRead(8'h04, 32'h0, audioTxPkg::respSlvErr);

		testName = "regReadback";	// Upper bits dropped
		axiWrite(audioTxPkg::regDmaAdrs, 32'hABCDE123, audioTxPkg::respOkay);
		axiRead(audioTxPkg::regDmaAdrs, 32'hABCDE123 & adrsMask, audioTxPkg::respOkay);
		axiWrite(audioTxPkg::regDmaLen, 32'hFFFFFFFF, audioTxPkg::respOkay);
		axiRead(audioTxPkg::regDmaLen, 32'hFFFFFFFF & adrsMask, audioTxPkg::respOkay);

		testName = "playback";
		playback(19'h100, 12);
		testName = "doneStatus";
		axiRead(audioTxPkg::regStatus, statDone, audioTxPkg::respOkay);
		axiWrite(audioTxPkg::regDmaEn, 32'h0, audioTxPkg::respOkay);
		axiRead(audioTxPkg::regStatus, 32'h0, audioTxPkg::respOkay);

		testName      = "underflow";	// Slow memory starves the FIFO
		forcedLatency = 40;
		playback(19'h200, 4);
		axiRead(audioTxPkg::regStatus, statDone | statUnder, audioTxPkg::respOkay);
		axiWrite(audioTxPkg::regStatus, 32'h0, audioTxPkg::respOkay);
		axiRead(audioTxPkg::regStatus, statDone, audioTxPkg::respOkay);
		axiWrite(audioTxPkg::regDmaEn, 32'h0, audioTxPkg::respOkay);
		axiRead(audioTxPkg::regStatus, 32'h0, audioTxPkg::respOkay);
		forcedLatency = 0;

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: audioTxTop.f
design/audioTxPkg.sv
design/audioTxCsr.sv
design/audioDmaCtrl.sv
design/sampleRateTimer.sv
design/audioSampleFifo.sv
design/audioTxTop.sv
bench/audioTxTop_properties.sv
bench/audioTxTb.sv

// File: Makefile
# Verilator flow for the audio playback subsystem

VERILATOR ?= verilator
TOP       ?= audioTxTb
RTL_TOP   ?= audioTxTop
FILELIST  ?= audioTxTop.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

SOURCES   = $(shell cat $(FILELIST))
RTL_SRCS  = $(filter design/%,$(SOURCES))
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the verdict
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
